//--- csi2RxPkg.sv
// Shared widths, datatype limits and decoder states for the CSI-2 receive path
package csi2RxPkg;

	//------------------------------------------------------------
	// Widths
	//------------------------------------------------------------
	localparam int laneByteWidth	= 8;		// One HS lane byte
	localparam int fifoWordWidth	= 17;		// {sync, lane1, lane0}
	localparam int pixelWidth		= 16;		// Payload word to the output
	localparam int wordCntWidth		= 16;		// Packet length in bytes
	localparam int dtWidth			= 6;		// Datatype field
	localparam int vcWidth			= 2;		// Virtual channel field
	localparam int eccWidth			= 8;		// Header ECC byte

	//------------------------------------------------------------
	// Datatype limits
	//------------------------------------------------------------
	// Lowest long data packet datatype
	// 0x00..0x13 are short packets or reserved here and get dropped
	localparam logic [dtWidth-1:0] dtLongMin = 6'h14;

	// FIFO depth when the top level leaves it alone
	localparam int fifoDepthDefault = 64;

	//------------------------------------------------------------
	// Decoder FSM
	//------------------------------------------------------------
	typedef enum logic [2:0]
	{
		stIdle		= 3'd0,		// Hunt for sync, header word 0
		stHdrLo		= 3'd1,		// Header low phase
		stHdrHi		= 3'd2,		// Word count MSB and ECC
		stTypeCheck	= 3'd3,		// Filter on datatype
		stPayload	= 3'd4		// Forward payload words
	} decState;

endpackage

//--- csi2LaneCapture.sv
`timescale 1ns/1ps

// Word clock front end
// Registers both HS lane bytes plus the sync flag and builds one FIFO word
module csi2LaneCapture import csi2RxPkg::*;
(
	input  logic						iWordClk,		// D-PHY word clock
	input  logic						qnHsRst,		// Async reset, active low
	input  logic [laneByteWidth-1:0]	iDataLane0,		// Lane 0 HS byte
	input  logic [laneByteWidth-1:0]	iDataLane1,		// Lane 1 HS byte
	input  logic						iSyncHs,		// First word of a packet
	input  logic						iValidHs,		// Data word qualifier
	output logic [fifoWordWidth-1:0]	wrData,			// To FIFO write port
	output logic						wrEn			// FIFO write strobe
);

	logic [laneByteWidth-1:0]	laneByte0;
	logic [laneByteWidth-1:0]	laneByte1;
	logic						syncFlag;

	//------------------------------------------------------------
	// Lane bytes, plain data path
	//------------------------------------------------------------
	always_ff @(posedge iWordClk)
	begin
		laneByte0 <= iDataLane0;
		laneByte1 <= iDataLane1;
	end

	// Control flags
	always_ff @(posedge iWordClk or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			syncFlag	<= 1'b0;
			wrEn		<= 1'b0;
		end
		else
		begin
			syncFlag	<= iSyncHs;
			wrEn		<= iValidHs | iSyncHs;	// Sync word is always written
		end
	end

	// Sync on top so the decoder sees it with the header word
	assign wrData = {syncFlag, laneByte1, laneByte0};

endmodule

//--- csi2DualClkFifo.sv
`timescale 1ns/1ps

// Async FIFO, word clock in, iSCLK out
// Gray pointers cross the domains, read side is first-word-fall-through
module csi2DualClkFifo import csi2RxPkg::*;
#(
	parameter int depth = fifoDepthDefault		// Power of two, 4 or more
)
(
	// Write side
	input  logic						iWordClk,
	input  logic [fifoWordWidth-1:0]	wrData,
	input  logic						wrEn,
	output logic						fifoFull,
	// Read side
	input  logic						iSCLK,
	output logic [fifoWordWidth-1:0]	rdData,
	output logic						rdValid,
	input  logic						rdReady,
	// Shared async reset
	input  logic						qnHsRst
);

	localparam int addrWidth = $clog2(depth);

	logic [fifoWordWidth-1:0]	mem [depth];

	logic [1:0]			wrRstSync, rdRstSync;
	logic				wrRstN, rdRstN;
	logic [addrWidth:0]	wrPtrBin, wrPtrGray, wrBinNext, wrGrayNext;
	logic [addrWidth:0]	rdPtrBin, rdPtrGray, rdBinNext, rdGrayNext;
	logic [addrWidth:0]	rdGraySync1, rdGraySync2;	// Read ptr in word clock
	logic [addrWidth:0]	wrGraySync1, wrGraySync2;	// Write ptr in iSCLK
	logic				rdEmpty;
	logic				wrInc, rdInc;

	//------------------------------------------------------------
	// Reset release, one synchronizer per domain
	//------------------------------------------------------------
	always_ff @(posedge iWordClk or negedge qnHsRst)
	begin
		if (!qnHsRst)	wrRstSync <= 2'b00;
		else			wrRstSync <= {wrRstSync[0], 1'b1};
	end

	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)	rdRstSync <= 2'b00;
		else			rdRstSync <= {rdRstSync[0], 1'b1};
	end

	assign wrRstN = wrRstSync[1];
	assign rdRstN = rdRstSync[1];

	//------------------------------------------------------------
	// Write domain
	//------------------------------------------------------------
	assign wrInc		= wrEn & ~fifoFull;			// Writes while full are lost
	assign wrBinNext	= wrPtrBin + wrInc;
	assign wrGrayNext	= (wrBinNext >> 1) ^ wrBinNext;

	always_ff @(posedge iWordClk)
	begin
		if (wrInc)
			mem[wrPtrBin[addrWidth-1:0]] <= wrData;
	end

	always_ff @(posedge iWordClk or negedge wrRstN)
	begin
		if (!wrRstN)
		begin
			wrPtrBin	<= '0;
			wrPtrGray	<= '0;
			rdGraySync1	<= '0;
			rdGraySync2	<= '0;
			fifoFull	<= 1'b0;
		end
		else
		begin
			wrPtrBin	<= wrBinNext;
			wrPtrGray	<= wrGrayNext;
			rdGraySync1	<= rdPtrGray;
			rdGraySync2	<= rdGraySync1;
			// Full when the top two bits differ and the rest match
			fifoFull	<= (wrGrayNext == {~rdGraySync2[addrWidth -: 2],
				rdGraySync2[addrWidth-2:0]});
		end
	end

	//------------------------------------------------------------
	// Read domain
	//------------------------------------------------------------
	assign rdValid		= ~rdEmpty;
	assign rdInc		= rdValid & rdReady;		// Word taken
	assign rdBinNext	= rdPtrBin + rdInc;
	assign rdGrayNext	= (rdBinNext >> 1) ^ rdBinNext;
	assign rdData		= mem[rdPtrBin[addrWidth-1:0]];	// Head word falls through

	always_ff @(posedge iSCLK or negedge rdRstN)
	begin
		if (!rdRstN)
		begin
			rdPtrBin	<= '0;
			rdPtrGray	<= '0;
			wrGraySync1	<= '0;
			wrGraySync2	<= '0;
			rdEmpty		<= 1'b1;
		end
		else
		begin
			rdPtrBin	<= rdBinNext;
			rdPtrGray	<= rdGrayNext;
			wrGraySync1	<= wrPtrGray;
			wrGraySync2	<= wrGraySync1;
			rdEmpty		<= (rdGrayNext == wrGraySync2);
		end
	end

	//------------------------------------------------------------
	// Checks
	//------------------------------------------------------------
	// Source must hold off on full
	aWrWhileFull: assert property (@(posedge iWordClk) disable iff (!wrRstN)
		wrEn |-> !fifoFull)
		else $error("FIFO written while full");

	// A read needs a word behind the synced write pointer
	aRdWhileEmpty: assert property (@(posedge iSCLK) disable iff (!rdRstN)
		rdInc |-> (rdPtrGray != wrGraySync2))
		else $error("FIFO read while empty");

endmodule

//--- csi2PacketDecoder.sv
`timescale 1ns/1ps

// Packet decoder on the iSCLK side
// Parses the two header words, filters on datatype, forwards payload words
module csi2PacketDecoder import csi2RxPkg::*;
(
	input  logic						iSCLK,
	input  logic						qnHsRst,
	// From FIFO
	input  logic [fifoWordWidth-1:0]	rdData,
	input  logic						rdValid,
	output logic						rdReady,
	// Pixel output
	output logic [pixelWidth-1:0]		pixData,
	output logic						pixValid,
	input  logic						pixReady,
	// Header fields of the current packet
	output logic [dtWidth-1:0]			dataType,
	output logic [vcWidth-1:0]			virtChan,
	output logic [wordCntWidth-1:0]		wordCnt,
	output logic [eccWidth-1:0]			ecc
);

	decState	state;

	logic [laneByteWidth-1:0]	lane0, lane1;
	logic						syncFlag;
	logic						take;			// FIFO word accepted
	logic						isLong;			// Packet passes the filter
	logic						lastWord;		// Final payload word
	logic [wordCntWidth-2:0]	payCnt;			// Payload words taken

	//------------------------------------------------------------
	// FIFO word fields
	//------------------------------------------------------------
	assign lane0	= rdData[laneByteWidth-1:0];
	assign lane1	= rdData[2*laneByteWidth-1:laneByteWidth];
	assign syncFlag	= rdData[fifoWordWidth-1];

	// Stall when the output register holds an untaken word
	// No word is consumed during the type check
	assign rdReady	= (state != stTypeCheck) & (~pixValid | pixReady);
	assign take		= rdValid & rdReady;

	// Byte count halved gives the 16-bit word count
	assign isLong	= (dataType >= dtLongMin) && (wordCnt[wordCntWidth-1:1] != '0);
	assign lastWord	= (payCnt == wordCnt[wordCntWidth-1:1] - 1'b1);

	//------------------------------------------------------------
	// FSM and header registers
	//------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			state		<= stIdle;
			payCnt		<= '0;
			dataType	<= '0;
			virtChan	<= '0;
			wordCnt		<= '0;
			ecc			<= '0;
		end
		else
		begin
			case (state)
			stIdle:
			begin
				// Non-sync words are dropped here
				if (take && syncFlag)
				begin
					dataType		<= lane0[dtWidth-1:0];
					virtChan		<= lane0[laneByteWidth-1 -: vcWidth];
					wordCnt[7:0]	<= lane1;			// Word count LSB
					state			<= stHdrHi;
				end
			end
			stHdrHi:
			begin
				if (take)
				begin
					wordCnt[15:8]	<= lane0;			// Word count MSB
					ecc				<= lane1;			// Passed through unchecked
					state			<= stTypeCheck;
				end
			end
			stTypeCheck:
			begin
				payCnt	<= '0;
				state	<= isLong ? stPayload : stIdle;
			end
			stPayload:
			begin
				if (take)
				begin
					payCnt <= payCnt + 1'b1;
					if (lastWord)
						state <= stIdle;
				end
			end
			default:	state <= stIdle;
			endcase
		end
	end

	//------------------------------------------------------------
	// Output register
	//------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qnHsRst)
	begin
		if (!qnHsRst)
			pixValid <= 1'b0;
		else if (take && state == stPayload)
			pixValid <= 1'b1;
		else if (pixReady)
			pixValid <= 1'b0;			// Word taken, nothing new
	end

	always_ff @(posedge iSCLK)
	begin
		if (take && state == stPayload)
			pixData <= {lane1, lane0};	// Lane 1 in the high byte
	end

	// Held word must not change under back-pressure
	aPixHold: assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		pixValid && !pixReady |=> pixValid && $stable(pixData))
		else $error("pixData changed while stalled");

endmodule

//--- csi2RxTop.sv
`timescale 1ns/1ps

// Two-lane CSI-2 receive path
// Word clock capture, async FIFO, packet decoder on iSCLK
module csi2RxTop import csi2RxPkg::*;
#(
	parameter int fifoDepth = fifoDepthDefault
)
(
	// D-PHY HS side
	input  logic						iWordClk,
	input  logic [laneByteWidth-1:0]	iDataLane0,
	input  logic [laneByteWidth-1:0]	iDataLane1,
	input  logic						iSyncHs,
	input  logic						iValidHs,
	output logic						fifoFull,		// Word clock domain
	// System side
	input  logic						iSCLK,
	input  logic						qnHsRst,
	output logic [pixelWidth-1:0]		pixData,
	output logic						pixValid,
	input  logic						pixReady,
	output logic [dtWidth-1:0]			dataType,
	output logic [vcWidth-1:0]			virtChan,
	output logic [wordCntWidth-1:0]		wordCnt,
	output logic [eccWidth-1:0]			ecc
);

	logic [fifoWordWidth-1:0]	wrData;
	logic						wrEn;
	logic [fifoWordWidth-1:0]	rdData;
	logic						rdValid;
	logic						rdReady;

	//------------------------------------------------------------
	// Word clock front end
	//------------------------------------------------------------
	csi2LaneCapture u_capture (
		.iWordClk	(iWordClk),
		.qnHsRst	(qnHsRst),
		.iDataLane0	(iDataLane0),
		.iDataLane1	(iDataLane1),
		.iSyncHs	(iSyncHs),
		.iValidHs	(iValidHs),
		.wrData		(wrData),
		.wrEn		(wrEn)
	);

	// Domain crossing
	csi2DualClkFifo #(
		.depth		(fifoDepth)
	) u_fifo (
		.iWordClk	(iWordClk),
		.wrData		(wrData),
		.wrEn		(wrEn),
		.fifoFull	(fifoFull),
		.iSCLK		(iSCLK),
		.rdData		(rdData),
		.rdValid	(rdValid),
		.rdReady	(rdReady),
		.qnHsRst	(qnHsRst)
	);

	//------------------------------------------------------------
	// Packet decoder
	//------------------------------------------------------------
	csi2PacketDecoder u_decoder (
		.iSCLK		(iSCLK),
		.qnHsRst	(qnHsRst),
		.rdData		(rdData),
		.rdValid	(rdValid),
		.rdReady	(rdReady),
		.pixData	(pixData),
		.pixValid	(pixValid),
		.pixReady	(pixReady),
		.dataType	(dataType),
		.virtChan	(virtChan),
		.wordCnt	(wordCnt),
		.ecc		(ecc)
	);

endmodule

//--- csi2RxTb.sv
`timescale 1ns/1ps

// Table-driven testbench for the two-lane CSI-2 receive path
module csi2RxTb import csi2RxPkg::*;
();

	localparam int numEntries	= 10;
	localparam int bpEntry		= 5;		// Long packet under heavy back-pressure
	localparam time sclkPeriod	= 40;
	localparam time wclkPeriod	= 28;		// Asynchronous to iSCLK
	localparam time drvDelay	= 3;		// Input skew after the rising edge

	// DUT ports
	logic						iWordClk, iSCLK, qnHsRst;
	logic [laneByteWidth-1:0]	iDataLane0, iDataLane1;
	logic						iSyncHs, iValidHs, fifoFull;
	logic [pixelWidth-1:0]		pixData;
	logic						pixValid, pixReady;
	logic [dtWidth-1:0]			dataType;
	logic [vcWidth-1:0]			virtChan;
	logic [wordCntWidth-1:0]	wordCnt;
	logic [eccWidth-1:0]		ecc;

	//------------------------------------------------------------
	// Packet table, one row per packet
	//------------------------------------------------------------
	int							tGarb [numEntries];		// Non-sync words before the header
	logic [dtWidth-1:0]			tDt [numEntries];
	logic [vcWidth-1:0]			tVc [numEntries];
	logic [wordCntWidth-1:0]	tWc [numEntries];		// Bytes
	logic [eccWidth-1:0]		tEcc [numEntries];
	bit							tRand [numEntries];		// Random pixReady gaps

	logic [pixelWidth-1:0]		stimWords [$];			// Garbage and payload, in send order
	logic [pixelWidth-1:0]		expPix [$];
	logic [dtWidth-1:0]			expDt [$];
	logic [vcWidth-1:0]			expVc [$];
	logic [wordCntWidth-1:0]	expWc [$];
	logic [eccWidth-1:0]		expEcc [$];
	bit							expRand [$];

	integer	seed		= 32'hff7f;
	int		pixErrs		= 0;
	int		hdrErrs		= 0;
	int		flagErrs	= 0;
	int		otherErrs	= 0;
	int		cycleCnt	= 0;
	int		cycleLimit	= 0;		// Set once the table is known
	int		curEntry	= -1;
	bit		bpFullSeen	= 1'b0;

	// Clocks
	initial
	begin
		iSCLK = 1'b0;
		forever #(sclkPeriod/2) iSCLK = ~iSCLK;
	end

	initial
	begin
		iWordClk = 1'b0;
		forever #(wclkPeriod/2) iWordClk = ~iWordClk;
	end

	csi2RxTop #(
		.fifoDepth	(16)		// Small so back-pressure reaches the source
	) u_dut (
		.iWordClk	(iWordClk),
		.iDataLane0	(iDataLane0),
		.iDataLane1	(iDataLane1),
		.iSyncHs	(iSyncHs),
		.iValidHs	(iValidHs),
		.fifoFull	(fifoFull),
		.iSCLK		(iSCLK),
		.qnHsRst	(qnHsRst),
		.pixData	(pixData),
		.pixValid	(pixValid),
		.pixReady	(pixReady),
		.dataType	(dataType),
		.virtChan	(virtChan),
		.wordCnt	(wordCnt),
		.ecc		(ecc)
	);

	//------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------
	task automatic checkPix(input logic [pixelWidth-1:0] expVal,
		input logic [pixelWidth-1:0] actVal);
		if (actVal !== expVal)
		begin
			pixErrs++;
			$display("FAIL %0t pixData expected 0x%h actual 0x%h", $time, expVal, actVal);
		end
	endtask

	task automatic checkHdr(
		input logic [dtWidth-1:0]		eDt,
		input logic [dtWidth-1:0]		aDt,
		input logic [vcWidth-1:0]		eVc,
		input logic [vcWidth-1:0]		aVc,
		input logic [wordCntWidth-1:0]	eWc,
		input logic [wordCntWidth-1:0]	aWc,
		input logic [eccWidth-1:0]		eEcc,
		input logic [eccWidth-1:0]		aEcc);
		if (aDt !== eDt)
		begin
			hdrErrs++;
			$display("FAIL %0t dataType expected 0x%h actual 0x%h", $time, eDt, aDt);
		end
		if (aVc !== eVc)
		begin
			hdrErrs++;
			$display("FAIL %0t virtChan expected %0d actual %0d", $time, eVc, aVc);
		end
		if (aWc !== eWc)
		begin
			hdrErrs++;
			$display("FAIL %0t wordCnt expected %0d actual %0d", $time, eWc, aWc);
		end
		if (aEcc !== eEcc)
		begin
			hdrErrs++;
			$display("FAIL %0t ecc expected 0x%h actual 0x%h", $time, eEcc, aEcc);
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			flagErrs++;
			$display("FAIL %0t %s expected %b actual %b", $time, name, expVal, actVal);
		end
	endtask

	task automatic printCounts();
		$display("Errors: pix %0d, header %0d, flag %0d, other %0d",
			pixErrs, hdrErrs, flagErrs, otherErrs);
	endtask

	//------------------------------------------------------------
	// Table and reference model
	//------------------------------------------------------------
	task automatic setEntry(input int e, input int garb, input logic [dtWidth-1:0] dt,
		input logic [vcWidth-1:0] vc, input logic [wordCntWidth-1:0] wc,
		input logic [eccWidth-1:0] eccByte, input bit rnd);
		tGarb[e]	= garb;
		tDt[e]		= dt;
		tVc[e]		= vc;
		tWc[e]		= wc;
		tEcc[e]		= eccByte;
		tRand[e]	= rnd;
	endtask

	// Long packets carry wc/2 payload words, short ones none
	function automatic int payloadWords(input logic [dtWidth-1:0] dt,
		input logic [wordCntWidth-1:0] wc);
		return (dt >= 6'h10) ? int'(wc >> 1) : 0;
	endfunction

	// Only long data packets above 0x13 come out
	function automatic bit isForwarded(input logic [dtWidth-1:0] dt);
		return dt >= 6'h14;
	endfunction

	task automatic loadTable();
		setEntry(0, 3, 6'h2A, 2'd1, 16'd8,   8'h5A, 1'b0);	// Garbage then RAW8
		setEntry(1, 0, 6'h01, 2'd0, 16'd3,   8'h11, 1'b0);	// Frame end, short
		setEntry(2, 0, 6'h1E, 2'd2, 16'd12,  8'h3C, 1'b0);	// Right after short
		setEntry(3, 0, 6'h12, 2'd0, 16'd6,   8'h77, 1'b0);	// Embedded, dropped
		setEntry(4, 0, 6'h2B, 2'd3, 16'd10,  8'h90, 1'b0);
		setEntry(5, 0, 6'h2A, 2'd0, 16'd128, 8'hC3, 1'b1);	// Fills the FIFO
		setEntry(6, 0, 6'h24, 2'd2, 16'd16,  8'h4E, 1'b1);
		setEntry(7, 2, 6'h2C, 2'd1, 16'd6,   8'hE1, 1'b0);
		setEntry(8, 0, 6'h00, 2'd3, 16'd1,   8'h0F, 1'b0);	// Frame start
		setEntry(9, 0, 6'h2A, 2'd2, 16'd4,   8'h66, 1'b0);
	endtask

	task automatic buildExpected();
		logic [pixelWidth-1:0]	w;
		int						total;
		total = 0;
		for (int e = 0; e < numEntries; e++)
		begin
			for (int g = 0; g < tGarb[e]; g++)
				stimWords.push_back(16'($random(seed)));
			for (int p = 0; p < payloadWords(tDt[e], tWc[e]); p++)
			begin
				w = 16'($random(seed));
				stimWords.push_back(w);
				if (isForwarded(tDt[e]))
				begin
					expPix.push_back(w);		// Lane 1 is the high byte
					expDt.push_back(tDt[e]);
					expVc.push_back(tVc[e]);
					expWc.push_back(tWc[e]);
					expEcc.push_back(tEcc[e]);
					expRand.push_back(tRand[e]);
				end
			end
			total += tGarb[e] + 2 + payloadWords(tDt[e], tWc[e]);
		end
		cycleLimit = 4 * total + 200;
	endtask

	//------------------------------------------------------------
	// Word clock source
	//------------------------------------------------------------
	// Idle slot after each word, so fifoFull is current when the next is sent
	task automatic driveWord(input logic sync, input logic [laneByteWidth-1:0] l0,
		input logic [laneByteWidth-1:0] l1);
		while (fifoFull)
		begin
			@(posedge iWordClk);
			#drvDelay;
		end
		iSyncHs		= sync;
		iValidHs	= 1'b1;
		iDataLane0	= l0;
		iDataLane1	= l1;
		@(posedge iWordClk);
		#drvDelay;
		iSyncHs		= 1'b0;
		iValidHs	= 1'b0;
		@(posedge iWordClk);
		#drvDelay;
	endtask

	task automatic sendPacket(input int e);
		logic [pixelWidth-1:0]	w;
		curEntry = e;
		repeat (tGarb[e])
		begin
			w = stimWords.pop_front();
			driveWord(1'b0, w[7:0], w[15:8]);
		end
		driveWord(1'b1, {tVc[e], tDt[e]}, tWc[e][7:0]);	// DI and WC LSB
		driveWord(1'b0, tWc[e][15:8], tEcc[e]);			// WC MSB and ECC
		for (int p = 0; p < payloadWords(tDt[e], tWc[e]); p++)
		begin
			w = stimWords.pop_front();
			driveWord(1'b0, w[7:0], w[15:8]);
		end
	endtask

	//------------------------------------------------------------
	// Sink side
	//------------------------------------------------------------
	always @(posedge iSCLK)
	begin
		#drvDelay;
		if (expRand.size() != 0 && expRand[0])
			pixReady = (($random(seed) & 3) == 0);		// Mostly stalled
		else
			pixReady = 1'b1;
	end

	// Inputs settle mid-cycle, so a transfer is seen here before its edge
	always @(negedge iSCLK)
	begin : outputCheck
		logic [pixelWidth-1:0]	ePix;
		logic [dtWidth-1:0]		eDt;
		logic [vcWidth-1:0]		eVc;
		logic [wordCntWidth-1:0] eWc;
		logic [eccWidth-1:0]	eEcc;
		if (qnHsRst && pixValid && pixReady)
		begin
			if (expPix.size() == 0)
			begin
				otherErrs++;
				$display("Unexpected pixel word 0x%h at %0t with nothing pending",
					pixData, $time);
			end
			else
			begin
				ePix	= expPix.pop_front();
				eDt		= expDt.pop_front();
				eVc		= expVc.pop_front();
				eWc		= expWc.pop_front();
				eEcc	= expEcc.pop_front();
				expRand.delete(0);
				checkPix(ePix, pixData);
				checkHdr(eDt, dataType, eVc, virtChan, eWc, wordCnt, eEcc, ecc);
			end
		end
	end

	always @(negedge iWordClk)
		if (fifoFull && curEntry == bpEntry)
			bpFullSeen = 1'b1;

	// Watchdog
	initial
	begin
		wait (cycleLimit != 0);
		while (cycleCnt < cycleLimit)
		begin
			@(posedge iSCLK);
			cycleCnt++;
		end
		otherErrs++;
		$display("Timeout after %0d iSCLK cycles with %0d pixel words still missing",
			cycleCnt, expPix.size());
		printCounts();
		$display("Regression failed");
		$finish;
	end

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		iDataLane0	= '0;
		iDataLane1	= '0;
		iSyncHs		= 1'b0;
		iValidHs	= 1'b0;
		pixReady	= 1'b0;
		qnHsRst		= 1'b0;
		loadTable();
		buildExpected();
		repeat (5) @(posedge iSCLK);
		#drvDelay;
		qnHsRst = 1'b1;
		@(negedge iSCLK);
		checkFlag("pixValid", 1'b0, pixValid);
		checkFlag("fifoFull", 1'b0, fifoFull);
		repeat (4) @(posedge iWordClk);		// Let the reset synchronizers release
		#drvDelay;
		for (int e = 0; e < numEntries; e++)
			sendPacket(e);
		curEntry = -1;
		while (expPix.size() != 0)
			@(posedge iSCLK);
		repeat (20) @(posedge iSCLK);		// Room for stray words
		if (!bpFullSeen)
		begin
			otherErrs++;
			$display("fifoFull never went high during the back-pressure packet");
		end
		printCounts();
		if (pixErrs + hdrErrs + flagErrs + otherErrs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- csi2RxTop.f
csi2RxPkg.sv
csi2LaneCapture.sv
csi2DualClkFifo.sv
csi2PacketDecoder.sv
csi2RxTop.sv
csi2RxTb.sv

//--- Bender.yml
package:
  name: csi2_rx

sources:
  - csi2RxPkg.sv
  - csi2LaneCapture.sv
  - csi2DualClkFifo.sv
  - csi2PacketDecoder.sv
  - csi2RxTop.sv
  - target: simulation
    files:
      - csi2RxTb.sv
